// File: pe_pkg.sv
package pe_pkg;

    //////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////

    localparam int SEQ_ADDR_W = 8;
    localparam int BR_ID_W    = 5;

    //////////////////////////////////////////////////
    // System bus
    //////////////////////////////////////////////////

    // Region code held in address bits 31:24
    typedef enum logic [7:0] {
        REGION_DMEM = 8'h01,
        REGION_RTC  = 8'h02,
        REGION_PLIC = 8'h04
    } region_e;

    typedef struct packed {
        logic        en;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_bus_req_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  we;
        logic [23:0] addr;
        logic [31:0] wdata;
    } dmem_req_t;

    // RTC register offsets
    localparam logic [3:0] RTC_MTIME_LO = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI = 4'h4;
    localparam logic [3:0] RTC_CMP_LO   = 4'h8;
    localparam logic [3:0] RTC_CMP_HI   = 4'hC;

    // PLIC register offsets
    localparam logic [3:0] PLIC_ENABLE  = 4'h0;
    localparam logic [3:0] PLIC_PENDING = 4'h4;

    //////////////////////////////////////////////////
    // Broadcast network
    //////////////////////////////////////////////////

    // Anything other than BR_SVC_MON goes to the service sink
    typedef enum logic [2:0] {
        BR_SVC_ALL = 3'd0,
        BR_SVC_TGT = 3'd1,
        BR_SVC_MON = 3'd2
    } br_svc_e;

    typedef struct packed {
        logic [31:0]           payload;
        logic [SEQ_ADDR_W-1:0] seq_target;
        logic [SEQ_ADDR_W-1:0] seq_source;
        logic [5:0]            producer;
        logic [7:0]            ksvc;
        logic [BR_ID_W-1:0]    id;
        br_svc_e               service;
    } br_flit_t;

    // Local request, source and id are filled in by the port
    typedef struct packed {
        logic [31:0]           payload;
        logic [SEQ_ADDR_W-1:0] seq_target;
        logic [5:0]            producer;
        logic [7:0]            ksvc;
        br_svc_e               service;
    } br_inject_t;

endpackage

// File: pe_bus_decode.sv
`timescale 1ns/10ps

module pe_bus_decode (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  pe_pkg::cpu_bus_req_t bus_i,

    output pe_pkg::dmem_req_t    dmem_o,
    input  logic [31:0]          dmem_data_i,
    input  logic [31:0]          rtc_data_i,
    input  logic [31:0]          plic_data_i,

    output logic                 rtc_sel_o,
    output logic                 plic_sel_o,
    output logic [31:0]          rdata_o
);

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////

    pe_pkg::region_e region;
    logic            dmem_sel;
    logic            rtc_sel;
    logic            plic_sel;

    assign region   = pe_pkg::region_e'(bus_i.addr[31:24]);

    assign dmem_sel = bus_i.en && (region == pe_pkg::REGION_DMEM);
    assign rtc_sel  = bus_i.en && (region == pe_pkg::REGION_RTC);
    assign plic_sel = bus_i.en && (region == pe_pkg::REGION_PLIC);

    assign rtc_sel_o  = rtc_sel;
    assign plic_sel_o = plic_sel;

    // Data memory sees only the offset inside its region
    assign dmem_o.en    = dmem_sel;
    assign dmem_o.we    = bus_i.we;
    assign dmem_o.addr  = bus_i.addr[23:0];
    assign dmem_o.wdata = bus_i.wdata;

    //////////////////////////////////////////////////
    // Read return
    //////////////////////////////////////////////////

    logic rtc_sel_q;
    logic plic_sel_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
        end else begin
            rtc_sel_q  <= rtc_sel;
            plic_sel_q <= plic_sel;
        end
    end

    // Data memory is the default, unmapped reads land there too
    always_comb begin
        if (rtc_sel_q) begin
            rdata_o = rtc_data_i;
        end else if (plic_sel_q) begin
            rdata_o = plic_data_i;
        end else begin
            rdata_o = dmem_data_i;
        end
    end

endmodule

// File: pe_rtc.sv
`timescale 1ns/10ps

module pe_rtc (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 sel_i,
    input  pe_pkg::cpu_bus_req_t bus_i,
    output logic [31:0]          rdata_o,

    output logic [63:0]          mtime_o,
    output logic                 mti_o
);

    // Byte-lane merge of a bus write into a 32-bit half
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_val,
        input logic [31:0] wdata,
        input logic [3:0]  we
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    logic [63:0] mtime_q;
    logic [63:0] mtime_d;
    logic [63:0] mtimecmp_q;
    logic [63:0] mtimecmp_d;
    logic [31:0] rdata_q;
    logic        mti_q;
    logic        wr_en;
    logic [3:0]  offset;

    assign wr_en  = sel_i && (|bus_i.we);
    assign offset = bus_i.addr[3:0];

    // A bus write to a half replaces that half of the count
    always_comb begin
        mtime_d    = mtime_q + 64'd1;
        mtimecmp_d = mtimecmp_q;
        if (wr_en) begin
            case (offset)
                pe_pkg::RTC_MTIME_LO:
                    mtime_d[31:0]     = merge_bytes(mtime_q[31:0], bus_i.wdata, bus_i.we);
                pe_pkg::RTC_MTIME_HI:
                    mtime_d[63:32]    = merge_bytes(mtime_q[63:32], bus_i.wdata, bus_i.we);
                pe_pkg::RTC_CMP_LO:
                    mtimecmp_d[31:0]  = merge_bytes(mtimecmp_q[31:0], bus_i.wdata, bus_i.we);
                pe_pkg::RTC_CMP_HI:
                    mtimecmp_d[63:32] = merge_bytes(mtimecmp_q[63:32], bus_i.wdata, bus_i.we);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            mti_q      <= 1'b0;
        end else begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
            mti_q      <= (mtime_q >= mtimecmp_q);
        end
    end

    // Read data for the decoder, one cycle after the request
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            case (offset)
                pe_pkg::RTC_MTIME_LO: rdata_q <= mtime_q[31:0];
                pe_pkg::RTC_MTIME_HI: rdata_q <= mtime_q[63:32];
                pe_pkg::RTC_CMP_LO:   rdata_q <= mtimecmp_q[31:0];
                pe_pkg::RTC_CMP_HI:   rdata_q <= mtimecmp_q[63:32];
                default:              rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign mtime_o = mtime_q;
    assign mti_o   = mti_q;

endmodule

// File: pe_plic.sv
`timescale 1ns/10ps

module pe_plic (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 sel_i,
    input  pe_pkg::cpu_bus_req_t bus_i,
    output logic [31:0]          rdata_o,

    input  logic                 ext_irq_i,
    input  logic                 irq_ack_i,
    output logic                 mei_o
);

    logic        irq_q;
    logic        irq_rise;
    logic        pending_q;
    logic        enable_q;
    logic        mei_q;
    logic [31:0] rdata_q;
    logic [3:0]  offset;

    assign offset   = bus_i.addr[3:0];
    assign irq_rise = ext_irq_i && !irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_q     <= 1'b0;
            pending_q <= 1'b0;
            enable_q  <= 1'b0;
            mei_q     <= 1'b0;
        end else begin
            irq_q <= ext_irq_i;
            // New edge takes priority over an acknowledge
            if (irq_rise) begin
                pending_q <= 1'b1;
            end else if (irq_ack_i) begin
                pending_q <= 1'b0;
            end
            if (sel_i && bus_i.we[0] && (offset == pe_pkg::PLIC_ENABLE)) begin
                enable_q <= bus_i.wdata[0];
            end
            mei_q <= pending_q && enable_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            case (offset)
                pe_pkg::PLIC_ENABLE:  rdata_q <= {31'b0, enable_q};
                pe_pkg::PLIC_PENDING: rdata_q <= {31'b0, pending_q};
                default:              rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign mei_o   = mei_q;

endmodule

// File: br_local_port.sv
`timescale 1ns/10ps

module br_local_port #(
    parameter logic [pe_pkg::SEQ_ADDR_W-1:0] SEQ_ADDR = '0
) (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Delivery from the router
    input  logic               rx_req_i,
    input  pe_pkg::br_flit_t   rx_flit_i,
    output logic               rx_ack_o,

    // Local sinks
    output logic               mon_req_o,
    output logic               svc_req_o,
    input  logic               mon_ack_i,
    input  logic               svc_ack_i,
    output pe_pkg::br_flit_t   sink_flit_o,

    // Local injector
    input  logic               inj_req_i,
    input  pe_pkg::br_inject_t inj_flit_i,
    output logic               inj_ack_o,

    // Injection into the router
    output logic               tx_req_o,
    output pe_pkg::br_flit_t   tx_flit_o,
    input  logic               tx_ack_i
);

    //////////////////////////////////////////////////
    // Delivery demux
    //////////////////////////////////////////////////

    logic is_mon;
    logic route_mon;
    logic route_mon_q;

    assign is_mon = (rx_flit_i.service == pe_pkg::BR_SVC_MON);

    // Keep the chosen sink after req drops, until its ack falls
    assign route_mon = rx_req_i ? is_mon : route_mon_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            route_mon_q <= 1'b0;
        end else begin
            route_mon_q <= route_mon;
        end
    end

    assign mon_req_o   = rx_req_i && is_mon;
    assign svc_req_o   = rx_req_i && !is_mon;
    assign sink_flit_o = rx_flit_i;
    assign rx_ack_o    = route_mon ? mon_ack_i : svc_ack_i;

    //////////////////////////////////////////////////
    // Injection stamper
    //////////////////////////////////////////////////

    logic                       tx_ack_q;
    logic [pe_pkg::BR_ID_W-1:0] id_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tx_ack_q <= 1'b0;
            id_q     <= '0;
        end else begin
            tx_ack_q <= tx_ack_i;
            // One id per accepted flit, wraps on its own
            if (tx_ack_i && !tx_ack_q) begin
                id_q <= id_q + 1'b1;
            end
        end
    end

    assign tx_req_o             = inj_req_i;
    assign tx_flit_o.payload    = inj_flit_i.payload;
    assign tx_flit_o.seq_target = inj_flit_i.seq_target;
    assign tx_flit_o.seq_source = SEQ_ADDR;
    assign tx_flit_o.producer   = inj_flit_i.producer;
    assign tx_flit_o.ksvc       = inj_flit_i.ksvc;
    assign tx_flit_o.id         = id_q;
    assign tx_flit_o.service    = inj_flit_i.service;
    assign inj_ack_o            = tx_ack_i;

endmodule

// File: pe_top.sv
`timescale 1ns/10ps

module pe_top #(
    parameter logic [15:0] ADDRESS = 16'h0000,
    parameter int          N_PE_X  = 2
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    // CPU data bus
    input  pe_pkg::cpu_bus_req_t bus_i,
    output logic [31:0]          rdata_o,

    // Data memory
    output pe_pkg::dmem_req_t    dmem_o,
    input  logic [31:0]          dmem_data_i,

    // Interrupts and time
    input  logic                 ext_irq_i,
    input  logic                 irq_ack_i,
    output logic                 mti_o,
    output logic                 mei_o,
    output logic [63:0]          mtime_o,

    // Broadcast delivery
    input  logic                 rx_req_i,
    input  pe_pkg::br_flit_t     rx_flit_i,
    output logic                 rx_ack_o,
    output logic                 mon_req_o,
    output logic                 svc_req_o,
    input  logic                 mon_ack_i,
    input  logic                 svc_ack_i,
    output pe_pkg::br_flit_t     sink_flit_o,

    // Broadcast injection
    input  logic                 inj_req_i,
    input  pe_pkg::br_inject_t   inj_flit_i,
    output logic                 inj_ack_o,
    output logic                 tx_req_o,
    output pe_pkg::br_flit_t     tx_flit_o,
    input  logic                 tx_ack_i
);

    // Row-major position, x in the upper byte and y in the lower
    localparam int SEQ_ADDR_INT = ADDRESS[7:0] * N_PE_X + ADDRESS[15:8];
    localparam logic [pe_pkg::SEQ_ADDR_W-1:0] SEQ_ADDR =
        SEQ_ADDR_INT[pe_pkg::SEQ_ADDR_W-1:0];

    //////////////////////////////////////////////////
    // Bus decode
    //////////////////////////////////////////////////

    logic        rtc_sel;
    logic        plic_sel;
    logic [31:0] rtc_rdata;
    logic [31:0] plic_rdata;

    pe_bus_decode u_decode (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .bus_i       (bus_i      ),
        .dmem_o      (dmem_o     ),
        .dmem_data_i (dmem_data_i),
        .rtc_data_i  (rtc_rdata  ),
        .plic_data_i (plic_rdata ),
        .rtc_sel_o   (rtc_sel    ),
        .plic_sel_o  (plic_sel   ),
        .rdata_o     (rdata_o    )
    );

    //////////////////////////////////////////////////
    // Timer and interrupt controller
    //////////////////////////////////////////////////

    pe_rtc u_rtc (
        .clk_i   (clk_i    ),
        .rst_ni  (rst_ni   ),
        .sel_i   (rtc_sel  ),
        .bus_i   (bus_i    ),
        .rdata_o (rtc_rdata),
        .mtime_o (mtime_o  ),
        .mti_o   (mti_o    )
    );

    pe_plic u_plic (
        .clk_i     (clk_i     ),
        .rst_ni    (rst_ni    ),
        .sel_i     (plic_sel  ),
        .bus_i     (bus_i     ),
        .rdata_o   (plic_rdata),
        .ext_irq_i (ext_irq_i ),
        .irq_ack_i (irq_ack_i ),
        .mei_o     (mei_o     )
    );

    //////////////////////////////////////////////////
    // Broadcast local port
    //////////////////////////////////////////////////

    br_local_port #(
        .SEQ_ADDR (SEQ_ADDR)
    ) u_br_port (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .rx_req_i    (rx_req_i   ),
        .rx_flit_i   (rx_flit_i  ),
        .rx_ack_o    (rx_ack_o   ),
        .mon_req_o   (mon_req_o  ),
        .svc_req_o   (svc_req_o  ),
        .mon_ack_i   (mon_ack_i  ),
        .svc_ack_i   (svc_ack_i  ),
        .sink_flit_o (sink_flit_o),
        .inj_req_i   (inj_req_i  ),
        .inj_flit_i  (inj_flit_i ),
        .inj_ack_o   (inj_ack_o  ),
        .tx_req_o    (tx_req_o   ),
        .tx_flit_o   (tx_flit_o  ),
        .tx_ack_i    (tx_ack_i   )
    );

endmodule

// File: tb_pe_ref.svh
`ifndef TB_PE_REF_SVH
`define TB_PE_REF_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Expected bus read from data memory, word addressed by bits 9:2
function automatic logic [31:0] expected_read(input logic [31:0] addr);
    return ref_mem[addr[9:2]];
endfunction

// Monitor flits go to the monitor sink, everything else to service
function automatic logic expect_mon(input pe_pkg::br_flit_t f);
    return f.service == pe_pkg::BR_SVC_MON;
endfunction

function automatic pe_pkg::br_flit_t expected_stamp(
    input pe_pkg::br_inject_t inj,
    input logic [7:0]         src,
    input logic [4:0]         id
);
    pe_pkg::br_flit_t f;
    f.payload    = inj.payload;
    f.seq_target = inj.seq_target;
    f.seq_source = src;
    f.producer   = inj.producer;
    f.ksvc       = inj.ksvc;
    f.id         = id;
    f.service    = inj.service;
    return f;
endfunction

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_dmem(input string name, input pe_pkg::dmem_req_t exp,
                          input pe_pkg::dmem_req_t act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

task automatic check_flit(input string name, input pe_pkg::br_flit_t exp,
                          input pe_pkg::br_flit_t act);
    if (act !== exp) begin
        $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
        abort_run();
    end
endtask

`endif

// File: tb_pe.sv
`timescale 1ns/10ps

module tb_pe;

    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 16;
    localparam logic [7:0]  TB_X       = 8'd3;
    localparam logic [7:0]  TB_Y       = 8'd2;
    localparam logic [15:0] TB_ADDRESS = {TB_X, TB_Y};
    localparam int          TB_N_PE_X  = 4;
    localparam int          N_DMEM     = 16;
    localparam int          N_FLIT     = 40;
    localparam int          N_INJ      = 40;
    localparam int          NUM_TESTS  = N_DMEM + N_FLIT + N_INJ + 6;
    // Elements are numbered row by row
    localparam int          SEQ_EXP    = TB_Y * TB_N_PE_X + TB_X;

    logic                 clk_i = 1'b0;
    logic                 rst_ni;
    pe_pkg::cpu_bus_req_t bus_i;
    logic [31:0]          rdata_o;
    pe_pkg::dmem_req_t    dmem_o;
    logic [31:0]          dmem_data_i;
    logic                 ext_irq_i, irq_ack_i, mti_o, mei_o;
    logic [63:0]          mtime_o;
    logic                 rx_req_i, rx_ack_o, mon_req_o, svc_req_o, mon_ack_i, svc_ack_i;
    pe_pkg::br_flit_t     rx_flit_i, sink_flit_o, tx_flit_o;
    logic                 inj_req_i, inj_ack_o, tx_req_o, tx_ack_i;
    pe_pkg::br_inject_t   inj_flit_i;

    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] rng_state = 32'd35096;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    `include "tb_pe_ref.svh"

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    pe_top #(.ADDRESS(TB_ADDRESS), .N_PE_X(TB_N_PE_X)) DUT (.*);

    // Synchronous data memory, read-first
    always @(posedge clk_i) begin
        if (dmem_o.en) begin
            if (|dmem_o.we) begin
                mem[dmem_o.addr[9:2]] <= dmem_o.wdata;
            end
            dmem_data_i <= mem[dmem_o.addr[9:2]];
        end
    end

    // One request cycle, result sampled at the following falling edge
    task automatic bus_access(input logic [31:0] addr, input logic [3:0] we,
                              input logic [31:0] wdata, output pe_pkg::dmem_req_t seen,
                              output logic [31:0] rdata);
        @(negedge clk_i);
        bus_i = '{en: 1'b1, we: we, addr: addr, wdata: wdata};
        #1;
        seen = dmem_o;
        @(negedge clk_i);
        bus_i = '0;
        rdata = rdata_o;
    endtask

    initial begin
        #((NUM_TESTS * 64 + RST_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not complete in the allowed time");
        abort_run();
    end

    initial begin
        pe_pkg::dmem_req_t  seen;
        pe_pkg::br_flit_t   fl;
        pe_pkg::br_inject_t inj;
        logic [31:0]        rd, rd2, addr, data, t;
        logic [31:0]        wr_addr [N_DMEM];
        logic [4:0]         id_exp;
        logic               exp_mon;

        for (int i = 0; i < 256; i++) begin
            mem[i]     = {8'hD0, i[7:0], ~i[7:0], 8'h5A ^ i[7:0]};
            ref_mem[i] = mem[i];
        end
        rst_ni = 1'b0;
        bus_i = '0;
        dmem_data_i = '0;
        {ext_irq_i, irq_ack_i, rx_req_i, mon_ack_i, svc_ack_i, inj_req_i, tx_ack_i} = '0;
        rx_flit_i = '0;
        inj_flit_i = '0;
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);

        check_bit("mti_o", 1'b0, mti_o);
        check_bit("mei_o", 1'b0, mei_o);
        check_bit("dmem_o.en", 1'b0, dmem_o.en);
        check_bit("mon_req_o", 1'b0, mon_req_o);
        check_bit("svc_req_o", 1'b0, svc_req_o);
        check_bit("tx_req_o", 1'b0, tx_req_o);

        ////////////////////////////////////////////////// Data memory
        for (int i = 0; i < N_DMEM; i++) begin
            rd = next_rand();
            addr = {pe_pkg::REGION_DMEM, rd[23:2], 2'b00};
            data = next_rand();
            wr_addr[i] = addr;
            bus_access(addr, 4'hF, data, seen, rd);
            check_dmem("dmem_o", '{en: 1'b1, we: 4'hF, addr: addr[23:0], wdata: data}, seen);
            ref_mem[addr[9:2]] = data;
        end
        for (int i = 0; i < N_DMEM; i++) begin
            bus_access(wr_addr[i], 4'h0, 32'h0, seen, rd);
            check_word("rdata_o", expected_read(wr_addr[i]), rd);
        end
        // Unmapped region 0x40
        for (int i = 0; i < 4; i++) begin
            rd = next_rand();
            addr = {8'h40, rd[23:2], 2'b00};
            bus_access(addr, i[0] ? 4'hF : 4'h0, next_rand(), seen, rd);
            check_bit("dmem_o.en", 1'b0, seen.en);
        end

        ////////////////////////////////////////////////// RTC
        data = next_rand();
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_CMP_LO}, 4'hF, data, seen, rd);
        t = next_rand() | 32'h8000_0000;
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_CMP_HI}, 4'hF, t, seen, rd);
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_CMP_LO}, 4'h0, 32'h0, seen, rd);
        check_word("mtimecmp_lo", data, rd);
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_CMP_HI}, 4'h0, 32'h0, seen, rd);
        check_word("mtimecmp_hi", t, rd);

        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_MTIME_LO}, 4'h0, 32'h0, seen, rd);
        // Counter is one cycle past the value read in the request cycle
        check_word("mtime_o", rd + 32'd1, mtime_o[31:0]);
        check_word("mtime_o_hi", 32'd0, mtime_o[63:32]);
        repeat (5) @(negedge clk_i);
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_MTIME_LO}, 4'h0, 32'h0, seen, rd2);
        // Back-to-back accesses are two cycles apart, plus the idle cycles
        check_word("mtime_delta", 32'd7, rd2 - rd);

        t = rd2 + 32'd20;
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_CMP_LO}, 4'hF, t, seen, rd);
        bus_access({pe_pkg::REGION_RTC, 20'h0, pe_pkg::RTC_CMP_HI}, 4'hF, 32'h0, seen, rd);
        check_bit("mti_o", 1'b0, mti_o);
        for (int i = 0; i < 64 && !mti_o; i++) begin
            @(negedge clk_i);
        end
        if (!mti_o) begin
            $display("mti_o never rose after mtimecmp was set ahead of mtime");
            abort_run();
        end
        repeat (8) begin
            @(negedge clk_i);
            check_bit("mti_o", 1'b1, mti_o);
        end

        ////////////////////////////////////////////////// PLIC
        ext_irq_i = 1'b1;
        @(negedge clk_i);
        ext_irq_i = 1'b0;
        repeat (2) @(negedge clk_i);
        check_bit("mei_o", 1'b0, mei_o);
        bus_access({pe_pkg::REGION_PLIC, 20'h0, pe_pkg::PLIC_PENDING}, 4'h0, 32'h0, seen, rd);
        check_word("plic_pending", 32'd1, rd);
        bus_access({pe_pkg::REGION_PLIC, 20'h0, pe_pkg::PLIC_ENABLE}, 4'h1, 32'd1, seen, rd);
        repeat (2) @(negedge clk_i);
        check_bit("mei_o", 1'b1, mei_o);
        irq_ack_i = 1'b1;
        @(negedge clk_i);
        irq_ack_i = 1'b0;
        repeat (2) @(negedge clk_i);
        check_bit("mei_o", 1'b0, mei_o);
        bus_access({pe_pkg::REGION_PLIC, 20'h0, pe_pkg::PLIC_PENDING}, 4'h0, 32'h0, seen, rd);
        check_word("plic_pending", 32'd0, rd);

        ////////////////////////////////////////////////// Delivery
        for (int i = 0; i < N_FLIT; i++) begin
            @(negedge clk_i);
            fl = pe_pkg::br_flit_t'({next_rand(), next_rand(), next_rand()});
            fl.service = pe_pkg::br_svc_e'(next_rand() & 32'h7);
            exp_mon = expect_mon(fl);
            rx_flit_i = fl;
            rx_req_i = 1'b1;
            #1;
            check_bit("mon_req_o", exp_mon, mon_req_o);
            check_bit("svc_req_o", !exp_mon, svc_req_o);
            check_flit("sink_flit_o", fl, sink_flit_o);
            check_bit("rx_ack_o", 1'b0, rx_ack_o);
            @(negedge clk_i);
            mon_ack_i = exp_mon;
            svc_ack_i = !exp_mon;
            #1;
            check_bit("rx_ack_o", 1'b1, rx_ack_o);
            @(negedge clk_i);
            rx_req_i = 1'b0;
            // Flit is free to change once req is low
            rx_flit_i.service = exp_mon ? pe_pkg::BR_SVC_ALL : pe_pkg::BR_SVC_MON;
            #1;
            check_bit("rx_ack_o", 1'b1, rx_ack_o);
            @(negedge clk_i);
            mon_ack_i = 1'b0;
            svc_ack_i = 1'b0;
            #1;
            check_bit("rx_ack_o", 1'b0, rx_ack_o);
        end

        ////////////////////////////////////////////////// Injection
        id_exp = 5'd0;
        for (int i = 0; i < N_INJ; i++) begin
            @(negedge clk_i);
            inj = pe_pkg::br_inject_t'({next_rand(), next_rand()});
            inj_flit_i = inj;
            inj_req_i = 1'b1;
            #1;
            check_bit("tx_req_o", 1'b1, tx_req_o);
            check_flit("tx_flit_o", expected_stamp(inj, 8'(SEQ_EXP), id_exp), tx_flit_o);
            @(negedge clk_i);
            tx_ack_i = 1'b1;
            #1;
            check_bit("inj_ack_o", 1'b1, inj_ack_o);
            @(negedge clk_i);
            inj_req_i = 1'b0;
            @(negedge clk_i);
            tx_ack_i = 1'b0;
            #1;
            check_bit("inj_ack_o", 1'b0, inj_ack_o);
            id_exp = id_exp + 5'd1;
        end

        @(negedge clk_i);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: flist.f
+incdir+.
pe_pkg.sv
pe_bus_decode.sv
pe_rtc.sv
pe_plic.sv
br_local_port.sv
pe_top.sv
tb_pe.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_pe
FLIST     ?= flist.f
LOG       ?= sim.log

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
